//--- design/obj_video_pkg.sv
// Object engine video geometry
// Table size, line widths, offsets and ROM/pixel widths shared by all blocks
package obj_video_pkg;

    // Object attribute table
    localparam int obj_count = 32;
    localparam int obj_bytes = 8;

    // Horizontal and vertical position width
    localparam int hpos_w = 9;

    // Lines above the score area carry no objects
    localparam int score_lines = 48;

    // Added to the 9-bit Y field
    localparam logic [hpos_w-1:0] y_offset = 9'd128;

    // 384 wrap plus 10 pixels of tile delay, taken modulo 512
    localparam logic [hpos_w-1:0] x_offset = 9'(384 + 10);

    // ROM word address width
    localparam int rom_aw = 17;

    // Palette in the upper nibble, colour in the lower one
    localparam int pxl_w = 8;

endpackage

//--- design/obj_types_pkg.sv
// Object engine data types
// Decoded object attributes and the request handed from scan to fetch
package obj_types_pkg;

    // One table entry after byte assembly
    typedef struct packed {
        logic [3:0]                      pal;
        logic [obj_video_pkg::hpos_w-1:0] ypos;
        logic [obj_video_pkg::hpos_w-1:0] xpos;
        logic [11:0]                     code;
        logic                            vflip;
        logic                            hflip;
        logic [1:0]                      hsize;
    } obj_attr_t;

    // One object to draw on the next line
    typedef struct packed {
        // Tile code followed by the row inside the tile
        logic [obj_video_pkg::rom_aw-2:0] rom_row;
        logic [3:0]                       pal;
        logic                             hflip;
        // First line buffer address
        logic [obj_video_pkg::hpos_w-1:0] buf_start;
    } draw_req_t;

endpackage

//--- design/obj_table_ram.sv
// Object attribute table
// 256x8 RAM, write-only CPU port and registered read port for the scan
module obj_table_ram (
    input  logic       clk,
    input  logic [7:0] cpu_addr,
    input  logic [7:0] cpu_din,
    input  logic       cpu_we,
    input  logic [7:0] scan_addr,
    output logic [7:0] scan_dout
);

    logic [7:0] mem [obj_video_pkg::obj_count * obj_video_pkg::obj_bytes];

    // CPU side
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
    end

    // Scan side, one clock of latency
    always_ff @(posedge clk) begin
        scan_dout <= mem[scan_addr];
    end

endmodule

//--- design/obj_line_match.sv
// Vertical hit test for one object
// Checks the object height against the line and works out the tile code and row
module obj_line_match (
    input  obj_types_pkg::obj_attr_t          attr,
    input  logic [obj_video_pkg::hpos_w-1:0]  vf,
    output logic                              hit,
    output logic [11:0]                       code_adj,
    output logic [3:0]                        tile_row
);

    logic [obj_video_pkg::hpos_w-1:0] ydiff;

    assign ydiff = vf - attr.ypos;

    // Tall objects take the upper row bits as the low code bits
    always_comb begin
        code_adj = attr.code;
        case (attr.hsize)
            2'd0: begin
                hit = ydiff < 9'd16;
            end
            2'd1: begin
                hit         = ydiff < 9'd32;
                code_adj[0] = ydiff[4] ^ attr.vflip;
            end
            2'd2: begin
                hit           = ydiff < 9'd64;
                code_adj[1:0] = ydiff[5:4] ^ {2{attr.vflip}};
            end
            default: begin
                hit           = ydiff < 9'd128;
                code_adj[2:0] = ydiff[6:4] ^ {3{attr.vflip}};
            end
        endcase
    end

    // Row inside the 16-line tile
    assign tile_row = ydiff[3:0] ^ {4{attr.vflip}};

endmodule

//--- design/obj_scan_ctrl.sv
// Object table scanner
// Walks all entries once per line, tests each against the next line
// and hands hits to the tile fetcher, stalling while it is busy
module obj_scan_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             LHBL,
    input  logic [obj_video_pkg::hpos_w-1:0] v,
    input  logic                             flip,
    output logic [7:0]                       scan_addr,
    input  logic [7:0]                       scan_dout,
    input  logic                             busy,
    output logic                             draw_start,
    output obj_types_pkg::draw_req_t         req
);

    logic [$clog2(obj_video_pkg::obj_count)-1:0] obj_cnt;
    logic [$clog2(obj_video_pkg::obj_bytes)-1:0] sub_cnt;
    logic                                        step_en;
    logic                                        lhbl_l;
    logic                                        line_start;
    logic                                        done;
    logic                                        match;
    logic [obj_video_pkg::hpos_w-1:0]            vf;
    obj_types_pkg::obj_attr_t                    attr;
    logic                                        hit;
    logic [11:0]                                 code_adj;
    logic [3:0]                                  tile_row;
    logic [11:0]                                 code_adj_q;
    logic [3:0]                                  tile_row_q;

    assign scan_addr  = {obj_cnt, sub_cnt};
    assign line_start = LHBL && !lhbl_l;

    obj_line_match u_match (
        .attr     (attr),
        .vf       (vf),
        .hit      (hit),
        .code_adj (code_adj),
        .tile_row (tile_row)
    );

    // Counters, line start and hit flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step_en    <= 1'b0;
            lhbl_l     <= 1'b0;
            obj_cnt    <= '0;
            sub_cnt    <= '0;
            done       <= 1'b1;
            match      <= 1'b0;
            draw_start <= 1'b0;
            vf         <= '0;
        end else begin
            step_en    <= ~step_en;
            draw_start <= 1'b0;
            if (step_en) begin
                lhbl_l <= LHBL;
                vf     <= v ^ {obj_video_pkg::hpos_w{flip}};
                if (line_start) begin
                    done    <= 1'b0;
                    obj_cnt <= '0;
                    sub_cnt <= '0;
                    match   <= 1'b0;
                end else if (!done) begin
                    if (sub_cnt != 3'd7) begin
                        sub_cnt <= sub_cnt + 3'd1;
                    end
                    if (sub_cnt == 3'd6) begin
                        match <= hit && (v >= obj_video_pkg::score_lines);
                    end
                    // Last step repeats while the fetcher holds an object
                    if (sub_cnt == 3'd7) begin
                        if (!match || !busy) begin
                            obj_cnt <= obj_cnt + 5'd1;
                            sub_cnt <= '0;
                            if (&obj_cnt) begin
                                done <= 1'b1;
                            end
                        end
                        if (!busy) begin
                            draw_start <= match;
                            match      <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // Attribute assembly from the table bytes
    always_ff @(posedge clk) begin
        if (step_en && !line_start && !done) begin
            case (sub_cnt)
                3'd0: attr.pal <= scan_dout[3:0];
                3'd2: attr.ypos[7:0] <= scan_dout;
                3'd3: attr.ypos <= {scan_dout[0], attr.ypos[7:0]} + obj_video_pkg::y_offset;
                3'd4: attr.code[7:0] <= scan_dout;
                3'd5: begin
                    {attr.vflip, attr.hflip} <= scan_dout[7:6] ^ {2{flip}};
                    attr.hsize               <= scan_dout[5:4];
                    attr.code[11:8]          <= scan_dout[3:0];
                end
                3'd6: begin
                    attr.xpos[7:0] <= scan_dout;
                    code_adj_q     <= code_adj;
                    tile_row_q     <= tile_row;
                end
                3'd7: attr.xpos <= {scan_dout[0], attr.xpos[7:0]};
                default: ;
            endcase
        end
    end

    // Request for the fetcher, valid by the draw_start pulse
    always_comb begin
        req.rom_row   = {code_adj_q, tile_row_q};
        req.pal       = attr.pal;
        req.hflip     = attr.hflip;
        req.buf_start = attr.xpos + obj_video_pkg::x_offset;
    end

endmodule

//--- design/obj_tile_fetch.sv
// Object tile fetcher
// Reads both 8-pixel halves of one tile row from the ROM, unpacks the
// bit planes and writes the pixels into the line buffer
module obj_tile_fetch (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             draw_start,
    input  obj_types_pkg::draw_req_t         req,
    output logic                             busy,
    output logic [obj_video_pkg::rom_aw-1:0] rom_addr,
    output logic                             rom_cs,
    input  logic [31:0]                      rom_data,
    input  logic                             rom_ok,
    output logic [obj_video_pkg::hpos_w-1:0] wr_addr,
    output logic [obj_video_pkg::pxl_w-1:0]  wr_data,
    output logic                             we
);

    logic [1:0]  rom_good;
    logic [2:0]  wr_cnt;
    logic        half_done;
    logic        start;
    logic        accept;
    logic [31:0] planes;
    logic [31:0] pxl_sr;
    logic [3:0]  cur_pal;
    logic        cur_hflip;
    logic [3:0]  colour;

    assign start  = draw_start && !busy;
    // Word is good after two clocks of rom_ok on the current address
    assign accept = busy && (rom_good == 2'b11) && !we;

    // Plane b, pixel j comes from nibble j of the word
    always_comb begin
        for (int j = 0; j < 8; j++) begin
            for (int b = 0; b < 4; b++) begin
                planes[8*b + j] = rom_data[4*j + b];
            end
        end
    end

    assign colour  = cur_hflip ? {pxl_sr[31], pxl_sr[23], pxl_sr[15], pxl_sr[7]}
                               : {pxl_sr[24], pxl_sr[16], pxl_sr[8], pxl_sr[0]};
    assign wr_data = {cur_pal, colour};

    // Fetch control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            rom_cs    <= 1'b0;
            we        <= 1'b0;
            rom_good  <= '0;
            wr_cnt    <= '0;
            half_done <= 1'b0;
        end else if (start) begin
            busy      <= 1'b1;
            rom_cs    <= 1'b1;
            rom_good  <= '0;
            wr_cnt    <= '0;
            half_done <= 1'b0;
        end else if (busy) begin
            rom_good <= {rom_good[0], rom_ok};
            if (accept) begin
                we <= 1'b1;
                // Address moves to the second half
                if (!half_done) begin
                    rom_good <= '0;
                end
            end
            if (we) begin
                wr_cnt <= wr_cnt + 3'd1;
                if (&wr_cnt) begin
                    we        <= 1'b0;
                    half_done <= 1'b1;
                    if (half_done) begin
                        busy   <= 1'b0;
                        rom_cs <= 1'b0;
                    end
                end
            end
        end
    end

    // Address and pixel data path
    always_ff @(posedge clk) begin
        if (start) begin
            // Right half first when mirrored
            rom_addr  <= {req.rom_row, req.hflip};
            cur_pal   <= req.pal;
            cur_hflip <= req.hflip;
            wr_addr   <= req.buf_start;
        end
        if (accept) begin
            if (!half_done) begin
                rom_addr[0] <= ~rom_addr[0];
            end
            pxl_sr <= planes;
        end
        if (we) begin
            pxl_sr  <= cur_hflip ? pxl_sr << 1 : pxl_sr >> 1;
            wr_addr <= wr_addr + 9'd1;
        end
    end

endmodule

//--- design/obj_line_buffer.sv
// Object line buffer
// Two 512-pixel halves, one written for the next line while the other
// is read out and cleared behind the read
module obj_line_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             LHBL,
    input  logic [obj_video_pkg::hpos_w-1:0] wr_addr,
    input  logic [obj_video_pkg::pxl_w-1:0]  wr_data,
    input  logic                             we,
    input  logic [obj_video_pkg::hpos_w-1:0] h,
    input  logic                             pxl_cen,
    output logic [obj_video_pkg::pxl_w-1:0]  pxl
);

    localparam int depth = 2 ** obj_video_pkg::hpos_w;

    logic [obj_video_pkg::pxl_w-1:0] mem [2][depth];
    logic                            bank;
    logic                            lhbl_l;

    // Front half toggles at the start of each line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank   <= 1'b0;
            lhbl_l <= 1'b0;
        end else begin
            lhbl_l <= LHBL;
            if (LHBL && !lhbl_l) begin
                bank <= ~bank;
            end
        end
    end

    // Back half writes skip colour 0 for transparency
    always_ff @(posedge clk) begin
        if (we && (wr_data[3:0] != 4'd0)) begin
            mem[~bank][wr_addr] <= wr_data;
        end
        // Erase behind the read so the half is clean for its next use
        if (pxl_cen) begin
            mem[bank][h] <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= mem[bank][h];
        end
    end

endmodule

//--- design/obj_engine.sv
// Object engine top level
// Table RAM, line scan, tile fetch and line buffer
module obj_engine (
    input  logic                             clk,
    input  logic                             rst,
    // CPU
    input  logic [7:0]                       cpu_addr,
    input  logic [7:0]                       cpu_din,
    input  logic                             cpu_we,
    // Video
    input  logic [obj_video_pkg::hpos_w-1:0] h,
    input  logic [obj_video_pkg::hpos_w-1:0] v,
    input  logic                             LHBL,
    input  logic                             pxl_cen,
    input  logic                             flip,
    // Tile ROM
    output logic [obj_video_pkg::rom_aw-1:0] rom_addr,
    output logic                             rom_cs,
    input  logic [31:0]                      rom_data,
    input  logic                             rom_ok,
    // Pixel output
    output logic [obj_video_pkg::pxl_w-1:0]  pxl
);

    logic [7:0]                       scan_addr;
    logic [7:0]                       scan_dout;
    logic                             busy;
    logic                             draw_start;
    obj_types_pkg::draw_req_t         req;
    logic [obj_video_pkg::hpos_w-1:0] wr_addr;
    logic [obj_video_pkg::pxl_w-1:0]  wr_data;
    logic                             we;

    obj_table_ram u_table (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .cpu_we    (cpu_we),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout)
    );

    obj_scan_ctrl u_scan (
        .clk        (clk),
        .rst        (rst),
        .LHBL       (LHBL),
        .v          (v),
        .flip       (flip),
        .scan_addr  (scan_addr),
        .scan_dout  (scan_dout),
        .busy       (busy),
        .draw_start (draw_start),
        .req        (req)
    );

    obj_tile_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .req        (req),
        .busy       (busy),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .we         (we)
    );

    obj_line_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .LHBL    (LHBL),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .we      (we),
        .h       (h),
        .pxl_cen (pxl_cen),
        .pxl     (pxl)
    );

endmodule

//--- test/obj_engine_assertions.sv
// Tile fetch protocol assertions
// Checks the draw_start and busy link and the buffer write window
module obj_engine_assertions (
    input logic clk,
    input logic rst,
    input logic draw_start,
    input logic busy,
    input logic we
);

    int assert_errors = 0;

    // A fetch only begins on a request
    busy_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(draw_start))
        else begin
            assert_errors++;
            $error("busy rose without a draw_start pulse");
        end

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        draw_start |-> !busy)
        else begin
            assert_errors++;
            $error("draw_start pulsed while the fetcher was busy");
        end

    // Writes stay inside the object
    we_inside_busy: assert property (@(posedge clk) disable iff (rst)
        we |-> busy)
        else begin
            assert_errors++;
            $error("line buffer write outside of a fetch");
        end

endmodule

bind obj_tile_fetch obj_engine_assertions u_assert (
    .clk        (clk),
    .rst        (rst),
    .draw_start (draw_start),
    .busy       (busy),
    .we         (we)
);

//--- test/tb_obj_engine.sv
// Object engine testbench
// Generates video timing, loads the object table and models the tile ROM,
// then compares line buffer pixels against the values in the stimulus file
module tb_obj_engine;

    logic        clk;
    logic        rst;
    logic [7:0]  cpu_addr;
    logic [7:0]  cpu_din;
    logic        cpu_we;
    logic [8:0]  h;
    logic [8:0]  v;
    logic        LHBL;
    logic        pxl_cen;
    logic        flip;
    logic [16:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data = '0;
    logic        rom_ok = 1'b0;
    logic [7:0]  pxl;

    string       kind [256];
    string       name [256];
    string       tag;
    string       test_name;
    int          fld [256][9];
    int          nrec = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    int          lines_total = 0;
    int          last_line = 0;
    int          fd;
    int          seed = 19822;
    int          rom_wait = 0;
    logic [16:0] last_addr = '0;

    obj_engine dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Tile ROM with a random ready delay after each address change
    always @(negedge clk) begin
        if (rom_addr !== last_addr) begin
            last_addr = rom_addr;
            rom_wait  = $unsigned($random(seed)) % 6;
        end
        if (rom_cs && rom_wait == 0) begin
            rom_ok = 1'b1;
        end else begin
            rom_ok = 1'b0;
            if (rom_wait != 0) begin
                rom_wait = rom_wait - 1;
            end
        end
        for (int k = 0; k < 8; k++) begin
            rom_data[4*k +: 4] = rom_addr[3:0] + 4'(k);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, checks: %0d, errors: %0d", cycles, checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

    task cpu_write(input int addr, input int data);
        @(negedge clk);
        cpu_addr = addr[7:0];
        cpu_din  = data[7:0];
        cpu_we   = 1'b1;
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    // One pixel takes four clocks and pxl is sampled after its read strobe
    task pixel_step(output logic [7:0] seen);
        @(negedge clk);
        pxl_cen = 1'b1;
        @(negedge clk);
        pxl_cen = 1'b0;
        seen    = pxl;
        if (h == 9'd383) begin
            h = '0;
            v = v + 9'd1;
        end else begin
            h = h + 9'd1;
        end
        LHBL = (h < 9'd256);
        repeat (2) @(negedge clk);
    endtask

    // Hidden objects sit on line 0 inside the score area
    task start_group(input int rec);
        test_name = name[rec];
        flip      = (fld[rec][0] != 0);
        for (int a = 0; a < 256; a++) begin
            cpu_write(a, (a % 8 == 2) ? 'h80 : (a % 8 == 3) ? 1 : 0);
        end
        h    = '0;
        v    = '0;
        LHBL = 1'b1;
    endtask

    task write_object(input int rec);
        for (int b = 0; b < 8; b++) begin
            cpu_write(fld[rec][0] * 8 + b, fld[rec][b+1]);
        end
    endtask

    task check_pixel(input int rec);
        logic [7:0] seen;
        while (v != fld[rec][0] || h != fld[rec][1]) begin
            pixel_step(seen);
        end
        pixel_step(seen);
        checks = checks + 1;
        if (seen !== 8'(fld[rec][2])) begin
            errors = errors + 1;
            $display("Fail %s: line %0d h %0d expected %02h actual %02h",
                     test_name, fld[rec][0], fld[rec][1], 8'(fld[rec][2]), seen);
        end
    endtask

    initial begin
        rst      = 1'b1;
        cpu_addr = '0;
        cpu_din  = '0;
        cpu_we   = 1'b0;
        h        = '0;
        v        = '0;
        LHBL     = 1'b1;
        pxl_cen  = 1'b0;
        flip     = 1'b0;
        fd = $fopen("test/obj_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/obj_stim.txt");
            $display("Test failures found");
            $finish;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "G") begin
                void'($fscanf(fd, "%s %d", name[nrec], fld[nrec][0]));
                lines_total = lines_total + 2;
                last_line   = 0;
            end else if (tag == "O") begin
                void'($fscanf(fd, "%d %h %h %h %h %h %h %h %h", fld[nrec][0],
                              fld[nrec][1], fld[nrec][2], fld[nrec][3], fld[nrec][4],
                              fld[nrec][5], fld[nrec][6], fld[nrec][7], fld[nrec][8]));
            end else if (tag == "C") begin
                void'($fscanf(fd, "%d %d %h", fld[nrec][0], fld[nrec][1], fld[nrec][2]));
                lines_total = lines_total + fld[nrec][0] - last_line;
                last_line   = fld[nrec][0];
            end else begin
                void'($fgets(tag, fd));
                continue;
            end
            kind[nrec] = tag;
            nrec       = nrec + 1;
        end
        $fclose(fd);
        // Table loads take about 600 clocks per record at most
        limit = lines_total * 1536 + nrec * 600 + 5000;
        repeat (10) @(negedge clk);
        // Idle outputs while reset is held
        checks = checks + 2;
        if (rom_cs !== 1'b0) begin
            errors = errors + 1;
            $display("Fail reset: rom_cs expected 0 actual %b", rom_cs);
        end
        if (pxl !== 8'h00) begin
            errors = errors + 1;
            $display("Fail reset: pxl expected 00 actual %02h", pxl);
        end
        rst = 1'b0;
        for (int r = 0; r < nrec; r++) begin
            if (kind[r] == "G") begin
                start_group(r);
            end else if (kind[r] == "O") begin
                write_object(r);
            end else begin
                check_pixel(r);
            end
        end
        errors = errors + dut0.u_fetch.u_assert.assert_errors;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- test/obj_stim.txt
# Records: G name flip | O index byte0..byte7 (hex) | C line h expected_pxl (hex)
# Y byte E4 01 gives ypos 100, X byte C8 gives buffer address 82
G single 0
O 0 05 00 E4 01 12 00 C8 00
C 104 81 00
C 104 82 56
C 104 97 5E
C 117 82 00
G flips 0
O 0 03 00 E4 01 12 C0 C8 00
C 104 83 3F
C 104 97 38
C 116 83 37
G tall 0
O 0 06 00 E4 01 12 10 C8 00
O 1 06 00 E4 01 12 20 F0 00
O 2 06 00 E4 01 12 30 18 01
C 132 83 6F
C 133 83 00
C 133 123 61
C 165 123 00
C 228 163 6F
C 229 163 00
G overlap 0
O 0 02 00 E4 01 12 00 C8 00
O 1 04 00 E4 01 12 00 C9 00
C 101 83 21
C 101 84 41
C 101 98 48
G score 0
O 0 07 00 A8 01 12 00 C8 00
C 47 83 00
C 49 83 71
G flipscr 1
O 0 01 00 AC 00 12 00 C8 00
C 196 83 00
C 212 83 15
C 213 83 00
G many 0
O 0 08 00 E4 01 12 00 C8 00
O 1 09 00 E4 01 12 00 D8 00
O 2 0A 00 E4 01 12 00 E8 00
O 3 0B 00 E4 01 12 00 F8 00
C 101 83 81
C 101 145 B8
C 104 129 AE

//--- obj_engine.f
design/obj_video_pkg.sv
design/obj_types_pkg.sv
design/obj_table_ram.sv
design/obj_line_match.sv
design/obj_scan_ctrl.sv
design/obj_tile_fetch.sv
design/obj_line_buffer.sv
design/obj_engine.sv
test/obj_engine_assertions.sv
test/tb_obj_engine.sv
